// ==== flist.f ====
snowball_pkg.sv
snowball_ram.sv
snowball_tlb.sv
snowball_cache_ctrl.sv
snowball_top.sv
tb_mem_model.sv
tb_snowball.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_snowball
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell grep -v '^+' $(FLIST))
PASS      = RESULT: PASS

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_snowball.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_snowball;

  import snowball_pkg::*;

  logic              CPU_CLK = 1'b0;
  logic              RST;
  logic [WORD_W-1:0] cpu_addr;
  logic [WORD_W-1:0] cpu_wdata;
  logic              cpu_we;
  logic              cpu_enable;
  logic              tlb_we;
  logic              cache_inhibit;
  logic              vmem_act;
  wire  [WORD_W-1:0] cpu_rdata;
  wire               cpu_busy;
  wire               mmu_fault;
  wire  [WORD_W-1:0] wb_adr;
  wire  [WORD_W-1:0] wb_dat_w;
  wire               wb_we;
  wire               wb_cyc;
  wire               wb_stb;
  wire  [WORD_W-1:0] wb_dat_r;
  wire               wb_ack;
  wire  [31:0]       bus_count;
  wire  [31:0]       last_adr;

  // reference model
  logic [WORD_W-1:0] ref_mem [logic [WORD_W-1:0]];
  logic              tlb_vld [2**TLB_IDX_W];
  logic [VTAG_W-1:0] tlb_vt [2**TLB_IDX_W];
  logic [VTAG_W-1:0] tlb_pt [2**TLB_IDX_W];
  logic              line_vld [2**IDX_W];
  logic [CTAG_W-1:0] line_tag [2**IDX_W];
  logic [WORD_W-1:0] line_dat [2**IDX_W];

  // expectations for the request in flight
  logic              chk_rd;
  logic              chk_adr;
  logic              exp_short;
  logic              exp_fault;
  logic              exp_wr;
  logic [WORD_W-1:0] exp_rdata;
  logic [WORD_W-1:0] exp_adr;
  logic [WORD_W-1:0] exp_wdat;
  logic [31:0]       exp_nbus;
  logic [31:0]       bus_snap;
  logic [31:0]       busy_cycles = '0;
  int                err_cnt = 0;
  int                timeout_cnt = 0;

  snowball_top dut0 (.*);
  tb_mem_model mem0 (.*);

  always #20 CPU_CLK = ~CPU_CLK;

  always @(posedge CPU_CLK)
  begin
    if (!cpu_busy)
      busy_cycles <= '0;
    else
      busy_cycles <= busy_cycles + 32'd1;
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_reset_idle: assert property (@(posedge CPU_CLK)
    $rose(RST) |-> !cpu_busy && !wb_cyc && !wb_stb && !mmu_fault)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t busy,cyc,stb,mmu_fault got %b%b%b%b expected 0000",
               $time, cpu_busy, wb_cyc, wb_stb, mmu_fault);
    end

  a_rdata: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) && chk_rd |-> cpu_rdata == exp_rdata)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t cpu_rdata got %h expected %h", $time, cpu_rdata, exp_rdata);
    end

  a_short: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) && exp_short |-> busy_cycles == 32'd1)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t cpu_busy cycles got %0d expected 1", $time, busy_cycles);
    end

  a_nbus: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) |-> bus_count == bus_snap + exp_nbus)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t bus_count got %0d expected %0d", $time, bus_count,
               bus_snap + exp_nbus);
    end

  a_fault: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) |-> mmu_fault == exp_fault)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t mmu_fault got %b expected %b", $time, mmu_fault, exp_fault);
    end

  a_adr: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) && chk_adr |-> last_adr == exp_adr)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t wb_adr got %h expected %h", $time, last_adr, exp_adr);
    end

  a_we: assert property (@(posedge CPU_CLK) disable iff (!RST)
    wb_cyc && wb_ack |-> wb_we == exp_wr)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t wb_we got %b expected %b", $time, wb_we, exp_wr);
    end

  a_wdat: assert property (@(posedge CPU_CLK) disable iff (!RST)
    wb_cyc && wb_ack && exp_wr |-> wb_dat_w == exp_wdat)
    else
    begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t wb_dat_w got %h expected %h", $time, wb_dat_w, exp_wdat);
    end

  // ------------------------------------------------------------
  // tasks
  // ------------------------------------------------------------
  task automatic close_run;
    $display("errors: %0d  timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    while (cpu_busy !== level && n < limit)
    begin
      @(negedge CPU_CLK);
      n = n + 1;
    end
    if (cpu_busy !== level)
    begin
      timeout_cnt = timeout_cnt + 1;
      $display("timeout: cpu_busy did not reach %b within %0d cycles", level, limit);
      close_run();
    end
  endtask

  task automatic request(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                         input logic we, input logic tlbw, input logic inh, input logic vm);
    bus_snap = bus_count;
    @(posedge CPU_CLK);
    cpu_enable    <= 1'b1;
    cpu_addr      <= addr;
    cpu_wdata     <= wdata;
    cpu_we        <= we;
    tlb_we        <= tlbw;
    cache_inhibit <= inh;
    vmem_act      <= vm;
    @(posedge CPU_CLK);
    cpu_enable <= 1'b0;  // accepted on this edge
    wait_busy(1'b1, 8);
    wait_busy(1'b0, 64);
    @(negedge CPU_CLK);  // past the edge that checks completion
  endtask

  task automatic backdoor(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data);
    mem0.poke(addr, data);
    ref_mem[addr] = data;
  endtask

  task automatic access(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                        input logic we, input logic inh, input logic vm);
    logic [TLB_IDX_W-1:0] ti;
    logic [IDX_W-1:0]     li;
    logic [VTAG_W-1:0]    pt;
    logic [WORD_W-1:0]    pa;
    logic                 hit;
    ti = addr[17:10];
    li = addr[9:2];
    pt = vm ? tlb_pt[ti] : addr[31:18];
    pa = {pt, addr[17:0]};
    exp_fault = vm && !(tlb_vld[ti] && tlb_vt[ti] == addr[31:18]);
    hit = !exp_fault && !we && !inh && line_vld[li] && line_tag[li] == {pt, ti};
    if (!exp_fault && !we && !ref_mem.exists(pa))
      backdoor(pa, $urandom);
    exp_short = hit;
    exp_nbus  = (exp_fault || hit) ? 32'd0 : 32'd1;
    chk_adr   = !exp_fault && !hit;
    chk_rd    = !exp_fault && !we;
    exp_adr   = pa;
    exp_wr    = we;
    exp_wdat  = wdata;
    exp_rdata = line_dat[li];
    if (!hit && !we && !exp_fault)
      exp_rdata = ref_mem[pa];
    request(addr, wdata, we, 1'b0, inh, vm);
    if (!exp_fault && we)
      ref_mem[pa] = wdata;
    if (!exp_fault && !hit && !inh)
    begin
      line_vld[li] = 1'b1;  // write-through also fills
      line_tag[li] = {pt, ti};
      line_dat[li] = we ? wdata : ref_mem[pa];
    end
  endtask

  task automatic tlb_write(input logic [TLB_IDX_W-1:0] ti, input logic [VTAG_W-1:0] vt,
                           input logic [VTAG_W-1:0] pt);
    tlb_word_u w;
    w.raw        = '0;
    w.entry.ptag = {2'b00, pt};
    w.entry.vtag = {2'b00, vt};
    exp_short = 1'b1;
    exp_nbus  = 32'd0;
    exp_fault = 1'b0;
    exp_wr    = 1'b0;
    chk_adr   = 1'b0;
    chk_rd    = 1'b0;
    request({14'h0, ti, 10'h0}, w.raw, 1'b0, 1'b1, 1'b0, 1'b1);
    tlb_vld[ti] = 1'b1;
    tlb_vt[ti]  = vt;
    tlb_pt[ti]  = pt;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial
  begin
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] d;
    void'($urandom(92));
    RST           = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    cpu_we        = 1'b0;
    cpu_enable    = 1'b0;
    tlb_we        = 1'b0;
    cache_inhibit = 1'b0;
    vmem_act      = 1'b0;
    chk_rd        = 1'b0;
    chk_adr       = 1'b0;
    exp_short     = 1'b0;
    exp_fault     = 1'b0;
    exp_wr        = 1'b0;
    exp_nbus      = '0;
    bus_snap      = '0;
    for (int i = 0; i < 2**IDX_W; i++)
    begin
      line_vld[i] = 1'b0;
      tlb_vld[i]  = 1'b0;
      tlb_vt[i]   = '0;
      tlb_pt[i]   = '0;
    end
    repeat (8) @(posedge CPU_CLK);
    RST <= 1'b1;
    @(negedge CPU_CLK);

    access(32'h0004_0510, '0, 1'b0, 1'b0, 1'b0);  // read miss
    access(32'h0004_0510, '0, 1'b0, 1'b0, 1'b0);  // then hit
    d = $urandom;
    access(32'h0008_0a24, d, 1'b1, 1'b0, 1'b0);
    access(32'h0008_0a24, '0, 1'b0, 1'b0, 1'b0);
    backdoor(32'h0004_0510, $urandom);
    access(32'h0004_0510, '0, 1'b0, 1'b1, 1'b0);  // bypass sees new word
    access(32'h0004_0510, '0, 1'b0, 1'b0, 1'b0);  // line still old

    tlb_write(8'h21, 14'h0123, 14'h2a5f);
    access({14'h0123, 8'h21, 10'h0c8}, '0, 1'b0, 1'b0, 1'b1);
    access({14'h0123, 8'h21, 10'h0c8}, '0, 1'b0, 1'b0, 1'b1);
    access({14'h0123, 8'h21, 10'h0f0}, $urandom, 1'b1, 1'b0, 1'b1);
    access({14'h0124, 8'h21, 10'h0c8}, '0, 1'b0, 1'b0, 1'b1);  // vtag mismatch
    access({14'h0001, 8'h7e, 10'h010}, $urandom, 1'b1, 1'b0, 1'b1);  // empty entry

    // few tags over 64 lines, so hits and conflicts both occur
    repeat (40)
    begin
      a = $urandom & 32'h000C_00FC;
      access(a, $urandom, ($urandom % 3) == 0, ($urandom % 5) == 0, 1'b0);
    end
    close_run();
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
  input  wire         CPU_CLK,
  input  wire         RST,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire  [31:0] wb_adr,
  input  wire  [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic [31:0] bus_count,
  output logic [31:0] last_adr
);

  logic [31:0] mem [logic [31:0]];
  logic [2:0]  wait_cnt;

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return {adr[15:0], adr[31:16]} ^ 32'h5ac3_96e1;  // never-written words
  endfunction

  task automatic poke(input logic [31:0] adr, input logic [31:0] dat);
    mem[adr] = dat;
  endtask

  always @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wb_ack    <= 1'b0;
      wb_dat_r  <= '0;
      wait_cnt  <= '0;
      bus_count <= '0;
      last_adr  <= '0;
    end
    else
    begin
      wb_ack <= 1'b0;  // single cycle ack
      if (wb_cyc && wb_stb && !wb_ack)
      begin
        if (wait_cnt != 3'd0)
          wait_cnt <= wait_cnt - 3'd1;
        else
        begin
          wb_ack    <= 1'b1;
          bus_count <= bus_count + 32'd1;
          last_adr  <= wb_adr;
          wait_cnt  <= 3'($urandom % 4);  // next ack delay
          if (wb_we)
            mem[wb_adr] = wb_dat_w;
          else
            wb_dat_r <= mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== snowball_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module snowball_top (
  input  wire                              CPU_CLK,
  input  wire                              RST,
  input  wire [snowball_pkg::WORD_W-1:0]   cpu_addr,
  input  wire [snowball_pkg::WORD_W-1:0]   cpu_wdata,
  input  wire                              cpu_we,
  input  wire                              cpu_enable,
  input  wire                              tlb_we,
  input  wire                              cache_inhibit,
  input  wire                              vmem_act,
  output wire [snowball_pkg::WORD_W-1:0]   cpu_rdata,
  output wire                              cpu_busy,
  output wire                              mmu_fault,
  output wire [snowball_pkg::WORD_W-1:0]   wb_adr,
  output wire [snowball_pkg::WORD_W-1:0]   wb_dat_w,
  output wire                              wb_we,
  output wire                              wb_cyc,
  output wire                              wb_stb,
  input  wire [snowball_pkg::WORD_W-1:0]   wb_dat_r,
  input  wire                              wb_ack
);

  import snowball_pkg::*;

  wire                lookup_en;
  wire [WORD_W-1:0]   lookup_addr;
  wire                tlb_vmem;
  wire                update_en;
  wire tlb_word_u     update_word;
  wire [VTAG_W-1:0]   ptag;
  wire                fault;
  wire                ram_re;
  wire [IDX_W-1:0]    ram_raddr;
  wire                data_we;
  wire [IDX_W-1:0]    data_waddr;
  wire [WORD_W-1:0]   data_wdata;
  wire [CTAG_W-1:0]   tag_wdata;
  wire [WORD_W-1:0]   data_rdata;
  wire [CTAG_W-1:0]   tag_rdata;

  snowball_cache_ctrl ctrl0 (
    .CPU_CLK, .RST,
    .cpu_addr, .cpu_wdata, .cpu_we, .cpu_enable, .tlb_we,
    .cache_inhibit, .vmem_act, .cpu_rdata, .cpu_busy, .mmu_fault,
    .lookup_en, .lookup_addr, .tlb_vmem, .update_en, .update_word,
    .ptag, .fault,
    .ram_re, .ram_raddr, .data_we, .data_waddr, .data_wdata, .tag_wdata,
    .data_rdata, .tag_rdata,
    .wb_adr, .wb_dat_w, .wb_we, .wb_cyc, .wb_stb, .wb_dat_r, .wb_ack
  );

  snowball_tlb tlb0 (
    .CPU_CLK, .RST,
    .lookup_en, .lookup_addr,
    .vmem        (tlb_vmem),
    .update_en, .update_word,
    .ptag, .fault
  );

  // ------------------------------------------------------------
  // cache line storage, data and tag share index and enables
  // ------------------------------------------------------------
  snowball_ram #(.DATA_W(WORD_W), .ADDR_W(IDX_W)) cache_data (
    .CPU_CLK (CPU_CLK),
    .re      (ram_re),
    .raddr   (ram_raddr),
    .rdata   (data_rdata),
    .we      (data_we),
    .waddr   (data_waddr),
    .wdata   (data_wdata)
  );

  snowball_ram #(.DATA_W(CTAG_W), .ADDR_W(IDX_W)) cache_tag (
    .CPU_CLK (CPU_CLK),
    .re      (ram_re),
    .raddr   (ram_raddr),
    .rdata   (tag_rdata),
    .we      (data_we),
    .waddr   (data_waddr),
    .wdata   (tag_wdata)
  );

endmodule

`default_nettype wire

// ==== snowball_cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module snowball_cache_ctrl (
  input  wire                              CPU_CLK,
  input  wire                              RST,
  // cpu side
  input  wire [snowball_pkg::WORD_W-1:0]   cpu_addr,
  input  wire [snowball_pkg::WORD_W-1:0]   cpu_wdata,
  input  wire                              cpu_we,
  input  wire                              cpu_enable,
  input  wire                              tlb_we,
  input  wire                              cache_inhibit,
  input  wire                              vmem_act,
  output logic [snowball_pkg::WORD_W-1:0]  cpu_rdata,
  output logic                             cpu_busy,
  output logic                             mmu_fault,
  // translation buffer
  output logic                             lookup_en,
  output logic [snowball_pkg::WORD_W-1:0]  lookup_addr,
  output logic                             tlb_vmem,
  output logic                             update_en,
  output snowball_pkg::tlb_word_u          update_word,
  input  wire [snowball_pkg::VTAG_W-1:0]   ptag,
  input  wire                              fault,
  // cache rams
  output logic                             ram_re,
  output logic [snowball_pkg::IDX_W-1:0]   ram_raddr,
  output logic                             data_we,
  output logic [snowball_pkg::IDX_W-1:0]   data_waddr,
  output logic [snowball_pkg::WORD_W-1:0]  data_wdata,
  output logic [snowball_pkg::CTAG_W-1:0]  tag_wdata,
  input  wire [snowball_pkg::WORD_W-1:0]   data_rdata,
  input  wire [snowball_pkg::CTAG_W-1:0]   tag_rdata,
  // wishbone master
  output logic [snowball_pkg::WORD_W-1:0]  wb_adr,
  output logic [snowball_pkg::WORD_W-1:0]  wb_dat_w,
  output logic                             wb_we,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  input  wire [snowball_pkg::WORD_W-1:0]   wb_dat_r,
  input  wire                              wb_ack
);

  import snowball_pkg::*;

  ctrl_state_e         state;
  logic                accept;
  logic                hit;
  logic                line_fill;
  logic [2**IDX_W-1:0] line_vld;
  logic [IDX_W-1:0]    req_idx;
  logic [WORD_W-1:0]   req_addr;
  logic [WORD_W-1:0]   req_wdata;
  logic [WORD_W-1:0]   rdata_buf;
  logic                req_we;
  logic                req_tlb;
  logic                req_inh;

  assign accept  = (state == ST_IDLE) && cpu_enable;
  assign req_idx = req_addr[9:2];
  assign cpu_busy = (state == ST_BUS) || (state == ST_DONE) || (state == ST_FAULT);

  // ------------------------------------------------------------
  // translation and ram hookup
  // ------------------------------------------------------------
  assign lookup_en   = accept;
  assign lookup_addr = (state == ST_IDLE) ? cpu_addr : req_addr;
  assign tlb_vmem    = vmem_act;
  assign update_en   = (state == ST_DONE) && req_tlb;
  assign update_word = req_wdata;  // entry view decoded in the tlb

  assign ram_re     = accept;
  assign ram_raddr  = cpu_addr[9:2];
  assign data_we    = (state == ST_DONE) && line_fill;
  assign data_waddr = req_idx;
  assign data_wdata = rdata_buf;
  assign tag_wdata  = wb_adr[31:10];  // ptag + tlb index

  assign hit = line_vld[req_idx] && (tag_rdata == {ptag, req_addr[17:10]});

  // ------------------------------------------------------------
  // fsm
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= ST_IDLE;
      line_vld  <= '0;
      line_fill <= 1'b0;
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      mmu_fault <= 1'b0;
    end
    else
    begin
      mmu_fault <= 1'b0;
      case (state)
        ST_IDLE:
          if (accept)
            state <= ST_LOOKUP;
        ST_LOOKUP:
        begin
          line_fill <= 1'b0;
          if (req_tlb)
            state <= ST_DONE;
          else if (fault)
            state <= ST_FAULT;
          else if (hit && !req_we && !req_inh)
            state <= ST_DONE;  // read hit
          else
          begin
            state     <= ST_BUS;
            wb_we     <= req_we;
            line_fill <= !req_inh;  // bypass leaves the line alone
          end
        end
        ST_BUS:
          if (!wb_cyc)
          begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end
          else if (wb_ack)
          begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            state  <= ST_DONE;
          end
        ST_DONE:
        begin
          if (line_fill)
            line_vld[req_idx] <= 1'b1;
          state <= ST_IDLE;
        end
        ST_FAULT:
        begin
          mmu_fault <= 1'b1;  // one cycle as busy falls
          state     <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // request and data path
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_addr  <= cpu_addr;
      req_wdata <= cpu_wdata;
      req_we    <= cpu_we;
      req_tlb   <= tlb_we;
      req_inh   <= cache_inhibit;
    end
    if (state == ST_LOOKUP)
    begin
      rdata_buf <= data_rdata;
      wb_adr    <= {ptag, req_addr[17:0]};
      wb_dat_w  <= req_wdata;
    end
    if ((state == ST_BUS) && wb_cyc && wb_ack)
      rdata_buf <= req_we ? req_wdata : wb_dat_r;
    if ((state == ST_DONE) && !req_we && !req_tlb)
      cpu_rdata <= rdata_buf;
  end

  a_stb_cyc: assert property (@(posedge CPU_CLK) disable iff (!RST)
    wb_stb |-> wb_cyc)
    else $error("wb_stb without wb_cyc");

  a_cyc_busy: assert property (@(posedge CPU_CLK) disable iff (!RST)
    wb_cyc |-> cpu_busy)
    else $error("bus cycle while cpu port idle");

endmodule

`default_nettype wire

// ==== snowball_tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module snowball_tlb (
  input  wire                              CPU_CLK,
  input  wire                              RST,
  input  wire                              lookup_en,
  input  wire [snowball_pkg::WORD_W-1:0]   lookup_addr,
  input  wire                              vmem,
  input  wire                              update_en,
  input  wire snowball_pkg::tlb_word_u     update_word,
  output logic [snowball_pkg::VTAG_W-1:0]  ptag,
  output logic                             fault
);

  import snowball_pkg::*;

  logic [TLB_IDX_W-1:0]    idx;
  logic [2**TLB_IDX_W-1:0] entry_vld;
  logic [WORD_W-1:0]       rd_raw;
  tlb_word_u               rd_entry;
  logic [VTAG_W-1:0]       vtag_q;
  logic                    vmem_q;
  logic                    valid_q;
  logic                    look_q;
  logic                    match;

  assign idx = lookup_addr[17:10];  // same index for lookup and update

  snowball_ram #(
    .DATA_W (WORD_W),
    .ADDR_W (TLB_IDX_W)
  ) tlb_ram (
    .CPU_CLK (CPU_CLK),
    .re      (lookup_en),
    .raddr   (idx),
    .rdata   (rd_raw),
    .we      (update_en),
    .waddr   (idx),
    .wdata   (update_word.raw)
  );

  assign rd_entry = rd_raw;

  // ------------------------------------------------------------
  // valid flops and lookup capture
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      entry_vld <= '0;
      look_q    <= 1'b0;
    end
    else
    begin
      look_q <= lookup_en;  // compare cycle follows
      if (update_en)
        entry_vld[idx] <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (lookup_en)
    begin
      valid_q <= entry_vld[idx];
      vmem_q  <= vmem;
      vtag_q  <= lookup_addr[31:18];
    end
  end

  assign match = valid_q && (rd_entry.entry.vtag[VTAG_W-1:0] == vtag_q);
  assign ptag  = vmem_q ? rd_entry.entry.ptag[VTAG_W-1:0] : vtag_q;
  assign fault = look_q && vmem_q && !match;

  // translation off never faults
  a_fault_vmem: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !vmem |-> !fault)
    else $error("tlb fault while translation is off");

endmodule

`default_nettype wire

// ==== snowball_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module snowball_ram #(
  parameter int DATA_W = snowball_pkg::WORD_W,
  parameter int ADDR_W = snowball_pkg::IDX_W
) (
  input  wire              CPU_CLK,
  input  wire              re,
  input  wire [ADDR_W-1:0] raddr,
  output logic [DATA_W-1:0] rdata,
  input  wire              we,
  input  wire [ADDR_W-1:0] waddr,
  input  wire [DATA_W-1:0] wdata
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    if (re)
      rdata <= mem[raddr];  // holds until next read
  end

endmodule

`default_nettype wire

// ==== snowball_pkg.sv ====
`default_nettype none

package snowball_pkg;

  // ------------------------------------------------------------
  // address fields
  // ------------------------------------------------------------
  localparam int WORD_W    = 32;  // data and address
  localparam int IDX_W     = 8;   // cache line index, addr 9:2
  localparam int TLB_IDX_W = 8;   // translation index, addr 17:10
  localparam int VTAG_W    = 14;  // page tag, addr 31:18
  localparam int CTAG_W    = VTAG_W + TLB_IDX_W;  // stored cache tag

  // ------------------------------------------------------------
  // translation entry, as written by the cpu
  // ------------------------------------------------------------
  typedef struct packed {
    logic [15:0] ptag;  // low 14 bits used
    logic [15:0] vtag;  // low 14 bits used
  } tlb_entry_t;

  typedef union packed {
    logic [WORD_W-1:0] raw;
    tlb_entry_t        entry;
  } tlb_word_u;

  // ------------------------------------------------------------
  // controller
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_BUS,
    ST_DONE,
    ST_FAULT
  } ctrl_state_e;

endpackage

`default_nettype wire
